/* Bender.yml */
package:
  name: load_store_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/cdb_pkg.sv
      - logic/lsu_pkg.sv
      - logic/addr_gen_station.sv
      - logic/load_queue.sv
      - logic/store_queue.sv
      - logic/data_ram.sv
      - logic/load_store_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/lsu_checker.sv
      - dv/lsu_tb.sv

/* build.f */
+incdir+logic
logic/cdb_pkg.sv
logic/lsu_pkg.sv
logic/addr_gen_station.sv
logic/load_queue.sv
logic/store_queue.sv
logic/data_ram.sv
logic/load_store_unit.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

/* dv/lsu_checker.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_checker (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_valid,
	input  lsu_pkg::mem_issue_t issue,
	input  logic                issue_ready,
	input  logic                load_valid,
	input  cdb_pkg::cdb_t       load_result,
	input  logic                load_ready,
	input  cdb_pkg::data_t      tag_val [1<<`ROB_WIDTH],
	output int                  errors,
	output int                  loads_checked,
	output int                  outstanding
);
	import cdb_pkg::*;
	import lsu_pkg::*;

	data_t    model [1<<`ADDR_WIDTH]; // memory in program order
	rob_tag_t exp_tag [$];
	data_t    exp_data [$];
	cdb_t     held;
	logic     stalled;
	string    test_name;

	task automatic set_test(string name);
		test_name = name;
	endtask

	// a waiting operand takes the value its tag will carry on the bus
	function automatic data_t operand_value(operand_t opd);
		return opd.ready ? opd.value : tag_val[opd.tag];
	endfunction

	function automatic addr_t op_address(mem_issue_t op);
		data_t sum;
		if (op.absolute)
			return op.imm.abs.addr;
		sum = operand_value(op.base) + {{(`DATA_WIDTH-16){op.imm.offset[15]}}, op.imm.offset};
		return sum[`ADDR_WIDTH-1:0];
	endfunction

	// negedge, so issue and result signals are settled
	always @(negedge clk) begin
		addr_t a;
		if (reset) begin
			errors        = 0;
			loads_checked = 0;
			stalled       = 1'b0;
			exp_tag.delete();
			exp_data.delete();
		end else begin
			if (stalled && (!load_valid || load_result !== held)) begin
				$display("[ERROR] %s: stalled load result expected %h actual %h",
				         test_name, held, load_result);
				errors++;
			end
			if (load_valid && load_ready) begin
				if (exp_tag.size() == 0) begin
					$display("%s: a load result with tag %0h came with no load outstanding",
					         test_name, load_result.tag);
					errors++;
				end else begin
					if (load_result.tag !== exp_tag[0]) begin
						$display("[ERROR] %s: load tag expected %0h actual %0h",
						         test_name, exp_tag[0], load_result.tag);
						errors++;
					end
					if (load_result.data !== exp_data[0]) begin
						$display("[ERROR] %s: load data for tag %0h expected %h actual %h",
						         test_name, exp_tag[0], exp_data[0], load_result.data);
						errors++;
					end
					void'(exp_tag.pop_front());
					void'(exp_data.pop_front());
					loads_checked++;
				end
			end
			stalled = load_valid && !load_ready;
			held    = load_result;
			if (issue_valid && issue_ready) begin
				a = op_address(issue);
				if (issue.is_store)
					model[a] = operand_value(issue.store_data);
				else begin
					exp_tag.push_back(issue.dest_tag);
					exp_data.push_back(model[a]); // youngest older store wins
				end
			end
		end
		outstanding = exp_tag.size();
	end

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb;
	import cdb_pkg::*;
	import lsu_pkg::*;

	localparam int N_TAGS = 1 << `ROB_WIDTH;
	localparam int N_OPS  = 32 + 16 + 12 + 120 + 6;
	localparam int LIMIT  = 40 * N_OPS + 1000;

	logic       clk;
	logic       reset;
	logic       issue_valid;
	mem_issue_t issue;
	logic       issue_ready;
	cdb_t       cdb;
	logic       load_valid;
	cdb_t       load_result;
	logic       load_ready;
	logic       commit_valid;
	logic       commit_ready;

	data_t       tag_val [N_TAGS];
	logic        pend [N_TAGS]; // tags still to be broadcast
	logic [31:0] lfsr;
	rob_tag_t    next_dest;
	logic        took;
	logic        ready_seen;
	int          seq; // program order of accepted ops
	int          store_seq [$];
	int          load_seq [$];
	int          own_errors;
	int          tests_done;
	int          last_errs;
	int          last_loads;
	int          cycles;
	int          commit_rate; // chances out of 4
	int          ready_rate;
	int          bcast_rate;
	int          chk_errors;
	int          chk_loads;
	int          chk_outstanding;
	int          total;
	string       cur_name;
	mem_issue_t  op;

	load_store_unit dut0 (
		.clk          (clk),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.issue_ready  (issue_ready),
		.cdb          (cdb),
		.load_valid   (load_valid),
		.load_result  (load_result),
		.load_ready   (load_ready),
		.commit_valid (commit_valid),
		.commit_ready (commit_ready)
	);

	lsu_checker chk0 (
		.clk           (clk),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.issue_ready   (issue_ready),
		.load_valid    (load_valid),
		.load_result   (load_result),
		.load_ready    (load_ready),
		.tag_val       (tag_val),
		.errors        (chk_errors),
		.loads_checked (chk_loads),
		.outstanding   (chk_outstanding)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d loads and %0d stores outstanding",
		         cycles, chk_outstanding, store_seq.size());
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// never hand out the tag that is on the bus right now
	function automatic int alloc_tag(data_t val);
		int t;
		t = int'(rand_bits(`ROB_WIDTH));
		for (int i = 0; i < N_TAGS; i++) begin
			if (!pend[t] && !(cdb.valid && cdb.tag == rob_tag_t'(t))) begin
				pend[t]    = 1'b1;
				tag_val[t] = val;
				return t;
			end
			t = (t + 1) % N_TAGS;
		end
		return -1;
	endfunction

	function automatic operand_t make_operand(data_t val, logic wait_tag);
		operand_t opd;
		int       t;
		t = wait_tag ? alloc_tag(val) : -1;
		if (t < 0)
			opd = '{ready: 1'b1, tag: rob_tag_t'(rand_bits(`ROB_WIDTH)), value: val};
		else
			opd = '{ready: 1'b0, tag: rob_tag_t'(t), value: ~val}; // stale value
		return opd;
	endfunction

	function automatic mem_issue_t make_op(logic is_store, logic absolute, addr_t addr,
	                                       logic wait_base, logic wait_data);
		mem_issue_t o;
		data_t      base;
		base       = rand_bits(32);
		o.is_store = is_store;
		o.absolute = absolute;
		o.dest_tag = next_dest;
		if (!is_store)
			next_dest = next_dest + 1'b1;
		if (absolute) begin
			o.base         = make_operand(base, 1'b0);
			o.imm.abs.pad  = rand_bits(16 - `ADDR_WIDTH);
			o.imm.abs.addr = addr;
		end else begin
			o.base       = make_operand(base, wait_base);
			o.imm.offset = 16'(addr) - base[15:0];
		end
		o.store_data = make_operand(rand_bits(32), is_store && wait_data);
		return o;
	endfunction

	function automatic addr_t window_addr();
		return addr_t'(rand_bits(4));
	endfunction

	// the ROB retires a store only once every older load has returned
	function automatic logic store_may_commit();
		return store_seq.size() != 0 &&
		       (load_seq.size() == 0 || store_seq[0] < load_seq[0]);
	endfunction

	task automatic drive_random();
		int t;
		commit_valid = commit_ready && store_may_commit() &&
		               (int'(rand_bits(2)) < commit_rate);
		load_ready   = int'(rand_bits(2)) < ready_rate;
		cdb          = '0;
		if (int'(rand_bits(2)) < bcast_rate) begin
			t = int'(rand_bits(`ROB_WIDTH));
			for (int i = 0; i < N_TAGS && !cdb.valid; i++) begin
				if (pend[t]) begin
					cdb     = '{valid: 1'b1, tag: rob_tag_t'(t), data: tag_val[t]};
					pend[t] = 1'b0;
				end
				t = (t + 1) % N_TAGS;
			end
		end
		// the renamer hands the broadcast to an op still on offer
		if (cdb.valid && issue_valid) begin
			if (!issue.base.ready && issue.base.tag == cdb.tag)
				issue.base = '{ready: 1'b1, tag: cdb.tag, value: cdb.data};
			if (!issue.store_data.ready && issue.store_data.tag == cdb.tag)
				issue.store_data = '{ready: 1'b1, tag: cdb.tag, value: cdb.data};
		end
	endtask

	task automatic tick();
		@(negedge clk);
		took       = issue_valid && issue_ready;
		ready_seen = issue_ready;
		if (commit_valid && commit_ready)
			void'(store_seq.pop_front());
		if (load_valid && load_ready && load_seq.size() != 0)
			void'(load_seq.pop_front());
		if (took) begin
			if (issue.is_store)
				store_seq.push_back(seq);
			else
				load_seq.push_back(seq);
			seq++;
		end
		@(posedge clk);
		#2;
		if (took)
			issue_valid = 1'b0;
		drive_random();
	endtask

	task automatic send(mem_issue_t o);
		issue       = o;
		issue_valid = 1'b1;
		do
			tick();
		while (!took);
	endtask

	task automatic drain();
		while (chk_outstanding != 0 || store_seq.size() != 0)
			tick();
	endtask

	task automatic expect_bit(string what, logic exp, logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: %s expected %0b actual %0b", cur_name, what, exp, act);
			own_errors++;
		end
	endtask

	// offer without valid, only issue_ready is looked at
	task automatic probe_ready(mem_issue_t o, logic exp, string what);
		issue       = o;
		issue_valid = 1'b0;
		tick();
		expect_bit(what, exp, ready_seen);
	endtask

	task automatic start_test(string name, int c_rate, int r_rate, int b_rate);
		cur_name    = name;
		commit_rate = c_rate;
		ready_rate  = r_rate;
		bcast_rate  = b_rate;
		chk0.set_test(name);
	endtask

	task automatic finish_test();
		int errs;
		errs = own_errors + chk_errors;
		if (errs == last_errs)
			$display("%s: ok, %0d loads checked", cur_name, chk_loads - last_loads);
		else
			$display("%s: failed with %0d errors", cur_name, errs - last_errs);
		last_errs  = errs;
		last_loads = chk_loads;
		tests_done++;
	endtask

	initial begin
		reset        = 1'b1;
		issue_valid  = 1'b0;
		issue        = '0;
		cdb          = '0;
		load_ready   = 1'b0;
		commit_valid = 1'b0;
		lfsr         = 32'hdded4484;
		next_dest    = '0;
		took         = 1'b0;
		seq          = 0;
		own_errors   = 0;
		tests_done   = 0;
		last_errs    = 0;
		last_loads   = 0;
		for (int t = 0; t < N_TAGS; t++) begin
			pend[t]    = 1'b0;
			tag_val[t] = '0;
		end
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		start_test("reset state", 0, 0, 0);
		@(negedge clk);
		expect_bit("load_valid", 1'b0, load_valid);
		expect_bit("commit_ready", 1'b0, commit_ready);
		expect_bit("issue_ready", 1'b1, issue_ready);
		@(posedge clk);
		#2;
		finish_test();

		start_test("absolute fill", 3, 3, 2);
		for (int a = 0; a < 16; a++)
			send(make_op(1'b1, 1'b1, addr_t'(a), 1'b0, 1'b0));
		drain();
		for (int a = 0; a < 16; a++)
			send(make_op(1'b0, 1'b1, addr_t'(a), 1'b0, 1'b0));
		drain();
		finish_test();

		start_test("late base", 3, 3, 1); // bus stays quiet most cycles
		for (int i = 0; i < 16; i++)
			send(make_op(rand_bits(1), 1'b0, window_addr(), 1'b1, rand_bits(1)));
		drain();
		finish_test();

		start_test("store forwarding", 4, 4, 3);
		for (int i = 0; i < 6; i++) begin
			op = make_op(1'b1, 1'b1, window_addr(), 1'b0, i[0]);
			send(op);
			send(make_op(1'b0, 1'b1, op.imm.abs.addr, 1'b0, 1'b0));
		end
		drain();
		finish_test();

		start_test("random traffic", 2, 2, 2);
		for (int i = 0; i < 120; i++)
			send(make_op(rand_bits(1), rand_bits(1), window_addr(), rand_bits(1), rand_bits(1)));
		drain();
		finish_test();

		// no commits and no bus, so both queues fill up
		start_test("queue full", 0, 0, 0);
		for (int i = 0; i < 4; i++)
			send(make_op(1'b1, 1'b1, window_addr(), 1'b0, 1'b1));
		probe_ready(make_op(1'b1, 1'b1, window_addr(), 1'b0, 1'b0), 1'b0, "store, store queue full");
		probe_ready(make_op(1'b0, 1'b1, window_addr(), 1'b0, 1'b0), 1'b1, "load, store queue full");
		for (int i = 0; i < 2; i++)
			send(make_op(1'b0, 1'b1, window_addr(), 1'b0, 1'b0));
		probe_ready(make_op(1'b0, 1'b1, window_addr(), 1'b0, 1'b0), 1'b0, "load, both full");
		probe_ready(make_op(1'b1, 1'b1, window_addr(), 1'b0, 1'b0), 1'b0, "store, both full");
		commit_rate = 3;
		ready_rate  = 2;
		bcast_rate  = 2;
		drain();
		finish_test();

		total = own_errors + chk_errors;
		$display("tests %0d, loads checked %0d, errors %0d", tests_done, chk_loads, total);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* logic/addr_gen_station.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module addr_gen_station (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 accept,
	input  lsu_pkg::mem_issue_t  issue,
	input  lsu_pkg::slot_t       new_slot,
	input  cdb_pkg::cdb_t        cdb,
	input  logic                 lq_pop,
	input  logic                 sq_pop,
	output logic                 agu_space,
	output lsu_pkg::addr_write_t addr_write
);
	import cdb_pkg::*;
	import lsu_pkg::*;

	typedef struct packed {
		logic        is_store;
		operand_t    base;
		logic [15:0] offset;
		slot_t       slot; // index in the target queue, tracks its pops
	} agu_entry_t;

	typedef logic [$clog2(`N_AGU+1)-1:0] agu_count_t;
	typedef logic [$clog2(`N_AGU)-1:0] agu_idx_t;

	agu_count_t count;
	agu_entry_t ent [`N_AGU]; // packed from 0, oldest first
	agu_entry_t upd [`N_AGU];
	agu_entry_t nxt [`N_AGU];
	agu_entry_t new_e;
	agu_entry_t sel;
	logic       push;
	logic       dispatch;
	agu_idx_t   disp_idx;
	data_t      sum;

	assign push = accept && !issue.absolute;

	always_comb begin
		new_e.is_store = issue.is_store;
		new_e.base     = capture(issue.base, cdb);
		new_e.offset   = issue.imm.offset;
		new_e.slot     = new_slot; // already accounts for this cycle's pop
	end

	always_comb begin
		for (int j = 0; j < `N_AGU; j++) begin
			upd[j]      = ent[j];
			upd[j].base = capture(ent[j].base, cdb);
			if (ent[j].is_store ? sq_pop : lq_pop)
				upd[j].slot = ent[j].slot - 1'b1;
		end
	end

	// oldest ready entry, only registered operands count
	always_comb begin
		dispatch = 1'b0;
		disp_idx = '0;
		for (int j = `N_AGU-1; j >= 0; j--) begin
			if (j < count && ent[j].base.ready) begin
				dispatch = 1'b1;
				disp_idx = agu_idx_t'(j);
			end
		end
	end

	assign sel = ent[disp_idx];
	assign sum = sel.base.value + `DATA_WIDTH'($signed(sel.offset));

	assign addr_write = '{
		valid:    dispatch,
		is_store: sel.is_store,
		slot:     sel.slot,
		addr:     sum[`ADDR_WIDTH-1:0]
	};

	// drop the dispatched entry and close the gap
	always_comb begin
		int n;
		n = 0;
		for (int j = 0; j < `N_AGU; j++)
			nxt[j] = upd[j];
		for (int j = 0; j < `N_AGU; j++) begin
			if (j < count && !(dispatch && disp_idx == j)) begin
				nxt[n] = upd[j];
				n++;
			end
		end
		if (push)
			nxt[n] = new_e;
	end

	assign agu_space = (count < `N_AGU) || dispatch;

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else
			count <= count + push - dispatch;
	end

	always_ff @(posedge clk) begin
		ent <= nxt;
	end

	a_agu_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> (count < `N_AGU) || dispatch);

endmodule

/* logic/cdb_pkg.sv */
`include "lsu_params.svh"

package cdb_pkg;

	typedef logic [`ROB_WIDTH-1:0] rob_tag_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;

	typedef struct packed {
		logic     ready; // value holds when set
		rob_tag_t tag;
		data_t    value;
	} operand_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		data_t    data;
	} cdb_t;

	// snoop one bus word for a waiting operand
	function automatic operand_t capture(operand_t opd, cdb_t bus);
		operand_t res;
		res = opd;
		if (!opd.ready && bus.valid && bus.tag == opd.tag) begin
			res.ready = 1'b1;
			res.value = bus.data;
		end
		return res;
	endfunction

endpackage

/* logic/data_ram.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module data_ram (
	input  logic                   clk,
	input  logic                   we,
	input  logic [`ADDR_WIDTH-1:0] waddr,
	input  logic [`DATA_WIDTH-1:0] wdata,
	input  logic [`ADDR_WIDTH-1:0] raddr,
	output logic [`DATA_WIDTH-1:0] rdata
);

	logic [`DATA_WIDTH-1:0] mem [0:(1<<`ADDR_WIDTH)-1];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // old word on a same-address write
	end

endmodule

/* logic/load_queue.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module load_queue (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 accept,
	input  lsu_pkg::mem_issue_t  issue,
	input  lsu_pkg::sq_count_t   store_count,
	input  lsu_pkg::addr_write_t addr_write,
	output lsu_pkg::sq_count_t   older_stores,
	output lsu_pkg::addr_t       head_addr,
	input  logic                 older_resolved,
	input  logic                 fwd_hit,
	input  cdb_pkg::data_t       fwd_data,
	input  cdb_pkg::data_t       ram_rdata,
	output lsu_pkg::addr_t       ram_raddr,
	output logic                 lq_space,
	output lsu_pkg::slot_t       next_slot,
	output logic                 lq_pop,
	input  logic                 sq_pop,
	output logic                 load_valid,
	output cdb_pkg::cdb_t        load_result,
	input  logic                 load_ready
);
	import cdb_pkg::*;
	import lsu_pkg::*;

	typedef struct packed {
		rob_tag_t  tag;
		logic      addr_valid;
		addr_t     addr;
		sq_count_t older; // stores ahead of this load
	} lq_entry_t;

	lq_count_t count;
	lq_entry_t ent [`N_LQ];
	lq_entry_t upd [`N_LQ];
	lq_entry_t nxt [`N_LQ];
	lq_entry_t new_e;
	logic      push;
	logic      eligible;
	logic      move;
	logic      res_valid;
	rob_tag_t  res_tag;
	data_t     res_data;

	assign push = accept && !issue.is_store;

	always_comb begin
		new_e.tag        = issue.dest_tag;
		new_e.addr_valid = issue.absolute;
		new_e.addr       = issue.imm.abs.addr;
		new_e.older      = store_count - sq_pop;
	end

	always_comb begin
		for (int j = 0; j < `N_LQ; j++) begin
			upd[j] = ent[j];
			if (addr_write.valid && !addr_write.is_store && addr_write.slot == j) begin
				upd[j].addr_valid = 1'b1;
				upd[j].addr       = addr_write.addr;
			end
			if (sq_pop && ent[j].older != '0)
				upd[j].older = ent[j].older - 1'b1;
		end
	end

	assign older_stores = ent[0].older;
	assign head_addr    = ent[0].addr;

	assign eligible = count != '0 && ent[0].addr_valid && older_resolved;
	assign move     = eligible && (!res_valid || load_ready);
	assign lq_pop   = move;

	assign next_slot = slot_t'(count - move);
	assign lq_space  = (count < `N_LQ) || move;

	always_comb begin
		for (int j = 0; j < `N_LQ; j++)
			nxt[j] = upd[j];
		if (move) begin
			for (int j = 0; j < `N_LQ-1; j++)
				nxt[j] = upd[j+1];
		end
		for (int j = 0; j < `N_LQ; j++) begin
			if (push && next_slot == j)
				nxt[j] = new_e;
		end
	end

	// read the next head so the word is there when it arrives
	assign ram_raddr = nxt[0].addr;

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else
			count <= count + push - move;
	end

	always_ff @(posedge clk) begin
		ent <= nxt;
	end

	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else if (move)
			res_valid <= 1'b1;
		else if (load_ready)
			res_valid <= 1'b0;
		if (move) begin
			res_tag  <= ent[0].tag;
			res_data <= fwd_hit ? fwd_data : ram_rdata;
		end
	end

	assign load_valid  = res_valid;
	assign load_result = '{valid: res_valid, tag: res_tag, data: res_data};

	a_result_hold: assert property (@(posedge clk) disable iff (reset)
		load_valid && !load_ready |=> load_valid && $stable(load_result));

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_valid,
	input  lsu_pkg::mem_issue_t issue,
	output logic                issue_ready,
	input  cdb_pkg::cdb_t       cdb,
	output logic                load_valid,
	output cdb_pkg::cdb_t       load_result,
	input  logic                load_ready,
	input  logic                commit_valid,
	output logic                commit_ready
);
	import cdb_pkg::*;
	import lsu_pkg::*;

	logic        accept;
	logic        agu_space;
	logic        lq_space;
	logic        sq_space;
	logic        lq_pop;
	logic        sq_pop;
	logic        older_resolved;
	logic        fwd_hit;
	logic        ram_we;
	slot_t       lq_next_slot;
	slot_t       sq_next_slot;
	slot_t       new_slot;
	sq_count_t   store_count;
	sq_count_t   older_stores;
	addr_t       head_addr;
	addr_t       ram_raddr;
	addr_t       ram_waddr;
	data_t       fwd_data;
	data_t       ram_rdata;
	data_t       ram_wdata;
	addr_write_t addr_write;

	// station slot only needed for register-relative ops
	assign issue_ready = (issue.is_store ? sq_space : lq_space) &&
	                     (issue.absolute || agu_space);
	assign accept      = issue_valid && issue_ready;
	assign new_slot    = issue.is_store ? sq_next_slot : lq_next_slot;

	addr_gen_station agu0 (
		.clk        (clk),
		.reset      (reset),
		.accept     (accept),
		.issue      (issue),
		.new_slot   (new_slot),
		.cdb        (cdb),
		.lq_pop     (lq_pop),
		.sq_pop     (sq_pop),
		.agu_space  (agu_space),
		.addr_write (addr_write)
	);

	load_queue lq0 (
		.clk            (clk),
		.reset          (reset),
		.accept         (accept),
		.issue          (issue),
		.store_count    (store_count),
		.addr_write     (addr_write),
		.older_stores   (older_stores),
		.head_addr      (head_addr),
		.older_resolved (older_resolved),
		.fwd_hit        (fwd_hit),
		.fwd_data       (fwd_data),
		.ram_rdata      (ram_rdata),
		.ram_raddr      (ram_raddr),
		.lq_space       (lq_space),
		.next_slot      (lq_next_slot),
		.lq_pop         (lq_pop),
		.sq_pop         (sq_pop),
		.load_valid     (load_valid),
		.load_result    (load_result),
		.load_ready     (load_ready)
	);

	store_queue sq0 (
		.clk            (clk),
		.reset          (reset),
		.accept         (accept),
		.issue          (issue),
		.cdb            (cdb),
		.addr_write     (addr_write),
		.older_stores   (older_stores),
		.load_addr      (head_addr),
		.older_resolved (older_resolved),
		.fwd_hit        (fwd_hit),
		.fwd_data       (fwd_data),
		.sq_space       (sq_space),
		.next_slot      (sq_next_slot),
		.store_count    (store_count),
		.commit_valid   (commit_valid),
		.commit_ready   (commit_ready),
		.sq_pop         (sq_pop),
		.ram_we         (ram_we),
		.ram_waddr      (ram_waddr),
		.ram_wdata      (ram_wdata)
	);

	data_ram ram0 (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (ram_raddr),
		.rdata (ram_rdata)
	);

endmodule

/* logic/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`define ROB_WIDTH 4
`define DATA_WIDTH 32
`define ADDR_WIDTH 10 // word address into the data RAM

`define N_AGU 2
`define N_LQ 2
`define N_SQ 4

`endif

/* logic/lsu_pkg.sv */
`include "lsu_params.svh"

package lsu_pkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// one index type for both queues
	typedef logic [$clog2(`N_SQ > `N_LQ ? `N_SQ : `N_LQ)-1:0] slot_t;

	typedef logic [$clog2(`N_LQ+1)-1:0] lq_count_t;
	typedef logic [$clog2(`N_SQ+1)-1:0] sq_count_t;

	typedef union packed {
		logic signed [15:0] offset; // register-relative
		struct packed {
			logic [15-`ADDR_WIDTH:0] pad; // ignored
			addr_t                   addr;
		} abs;
	} mem_imm_u;

	typedef struct packed {
		logic               is_store;
		logic               absolute;
		cdb_pkg::rob_tag_t  dest_tag;
		cdb_pkg::operand_t  base;
		cdb_pkg::operand_t  store_data;
		mem_imm_u           imm;
	} mem_issue_t;

	typedef struct packed {
		logic  valid;
		logic  is_store; // selects the queue
		slot_t slot;
		addr_t addr;
	} addr_write_t;

endpackage

/* logic/store_queue.sv */
`timescale 1ns/1ps
`include "lsu_params.svh"

module store_queue (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 accept,
	input  lsu_pkg::mem_issue_t  issue,
	input  cdb_pkg::cdb_t        cdb,
	input  lsu_pkg::addr_write_t addr_write,
	input  lsu_pkg::sq_count_t   older_stores,
	input  lsu_pkg::addr_t       load_addr,
	output logic                 older_resolved,
	output logic                 fwd_hit,
	output cdb_pkg::data_t       fwd_data,
	output logic                 sq_space,
	output lsu_pkg::slot_t       next_slot,
	output lsu_pkg::sq_count_t   store_count,
	input  logic                 commit_valid,
	output logic                 commit_ready,
	output logic                 sq_pop,
	output logic                 ram_we,
	output lsu_pkg::addr_t       ram_waddr,
	output cdb_pkg::data_t       ram_wdata
);
	import cdb_pkg::*;
	import lsu_pkg::*;

	typedef struct packed {
		logic     addr_valid;
		addr_t    addr;
		operand_t data;
	} sq_entry_t;

	sq_count_t count;
	sq_entry_t ent [`N_SQ]; // head at 0
	sq_entry_t upd [`N_SQ];
	sq_entry_t nxt [`N_SQ];
	sq_entry_t new_e;
	logic      push;
	logic      js_valid; // store committed last cycle
	addr_t     js_addr;
	data_t     js_data;

	assign push = accept && issue.is_store;

	always_comb begin
		new_e.addr_valid = issue.absolute;
		new_e.addr       = issue.imm.abs.addr;
		new_e.data       = capture(issue.store_data, cdb);
	end

	always_comb begin
		for (int j = 0; j < `N_SQ; j++) begin
			upd[j]      = ent[j];
			upd[j].data = capture(ent[j].data, cdb);
			if (addr_write.valid && addr_write.is_store && addr_write.slot == j) begin
				upd[j].addr_valid = 1'b1;
				upd[j].addr       = addr_write.addr;
			end
		end
	end

	assign commit_ready = count != '0 && ent[0].addr_valid && ent[0].data.ready;
	assign sq_pop       = commit_valid && commit_ready;

	assign next_slot   = slot_t'(count - sq_pop);
	assign sq_space    = (count < `N_SQ) || sq_pop;
	assign store_count = count;

	always_comb begin
		for (int j = 0; j < `N_SQ; j++)
			nxt[j] = upd[j];
		if (sq_pop) begin
			for (int j = 0; j < `N_SQ-1; j++)
				nxt[j] = upd[j+1];
		end
		for (int j = 0; j < `N_SQ; j++) begin
			if (push && next_slot == j)
				nxt[j] = new_e;
		end
	end

	// later matches override, so the youngest older store wins
	always_comb begin
		older_resolved = 1'b1;
		fwd_hit        = js_valid && js_addr == load_addr; // RAM not yet updated for it
		fwd_data       = js_data;
		for (int j = 0; j < `N_SQ; j++) begin
			if (j < older_stores) begin
				if (!(ent[j].addr_valid && ent[j].data.ready))
					older_resolved = 1'b0;
				if (ent[j].addr == load_addr) begin
					fwd_hit  = 1'b1;
					fwd_data = ent[j].data.value;
				end
			end
		end
	end

	assign ram_we    = sq_pop;
	assign ram_waddr = ent[0].addr;
	assign ram_wdata = ent[0].data.value;

	always_ff @(posedge clk) begin
		if (reset) begin
			count    <= '0;
			js_valid <= 1'b0;
		end else begin
			count    <= count + push - sq_pop;
			js_valid <= sq_pop;
		end
	end

	always_ff @(posedge clk) begin
		ent     <= nxt;
		js_addr <= ent[0].addr;
		js_data <= ent[0].data.value;
	end

	a_commit_ready: assert property (@(posedge clk) disable iff (reset)
		commit_valid |-> commit_ready);

endmodule
